// ==== tb.f ====
verilog/soc_pkg.sv
verilog/burst_ram.sv
verilog/uart_tx.sv
verilog/ramio.sv
verilog/flash_loader.sv
verilog/top.sv
bench/top_properties.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the boot subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top -o tb_top_sim
then
  echo "FAIL: compile error"
  exit 1
fi

./obj_dir/tb_top_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "FAIL: simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL: pass message not found in sim.log"
exit 1

// ==== bench/tb_top.sv ====
// tb_top
// boot subsystem testbench: spi flash model filled by an lcg,
// uart receiver, checksum and led checks against the flash contents
`timescale 1ns/100ps

module tb_top
  import soc_pkg::*;
();

  localparam int FLASH_BYTES = 512;
  localparam int BOOT_TIMEOUT = 5000;  // cycles
  localparam int FRAME_TIMEOUT = 20 * UART_CLKS_PER_BIT;
  localparam int IDLE_CYCLES = 200;

  logic        clk;
  logic        arst_n;
  logic [5:0]  led;
  logic        uart_tx;
  logic        flash_cs_n;
  logic        flash_clk;
  logic        flash_mosi;
  logic        flash_miso = 1'b0;

  byte_t       flash_mem [FLASH_BYTES];
  byte_t       expected_sum;
  byte_t       rx_byte;
  logic        transfer_done = 1'b0;

  // spi flash model state
  logic        prev_sck = 1'b0;
  logic        prev_cs_n = 1'b1;
  logic [31:0] cmd_sr = '0;       // command and address in
  int unsigned rise_cnt = 0;      // sck rising edges since cs_n fell
  int unsigned data_bit = 0;      // data bits handed out
  int unsigned rd_addr = 0;
  logic        out_bit = 1'b0;

  top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .led       (led),
    .uart_tx   (uart_tx),
    .flash_cs_n(flash_cs_n),
    .flash_clk (flash_clk),
    .flash_miso(flash_miso),
    .flash_mosi(flash_mosi)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("tests failed");
    $fatal(1, "timeout");
  endtask

  task automatic wait_boot_done();
    int n;
    n = 0;
    while (led[0] !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > BOOT_TIMEOUT) abort_on_timeout("led[0] boot done");
    end
  endtask

  // start bit found, then sample each bit in its middle
  task automatic receive_frame(output byte_t data);
    int n;
    n = 0;
    while (uart_tx !== 1'b0) begin
      @(posedge clk);
      n++;
      if (n > BOOT_TIMEOUT) abort_on_timeout("UART start bit");
    end
    repeat (UART_CLKS_PER_BIT / 2 - 1) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (UART_CLKS_PER_BIT) @(posedge clk);
      data[i] = uart_tx;  // lsb first
    end
    n = 0;
    while (u_dut.u_ramio.u_uart_tx.busy !== 1'b0) begin
      @(posedge clk);
      n++;
      if (n > FRAME_TIMEOUT) abort_on_timeout("end of UART frame");
    end
  endtask

  task automatic check_idle();
    int n;
    n = 0;
    while (led[5] !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > FRAME_TIMEOUT) abort_on_timeout("ramio idle on led[5]");
    end
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      assert (uart_tx === 1'b1 && led[5] === 1'b1 && led[0] === 1'b1)
        else report_error("UART line or LEDs not idle after boot");
    end
  endtask

  // --------------------------------------------------
  // spi flash model, mode 0
  // --------------------------------------------------
  always @(negedge clk) begin
    if (flash_cs_n === 1'b1) begin
      if (prev_cs_n === 1'b0) begin  // end of transfer
        assert (rise_cnt == 32 + 8 * FLASH_TRANSFER_BYTE_COUNT)
          else report_error($sformatf("flash saw %0d sck edges", rise_cnt));
        transfer_done = 1'b1;
      end
      rise_cnt = 0;
      data_bit = 0;
      out_bit  = 1'b0;
    end else if (flash_clk === 1'b1 && !prev_sck) begin
      if (rise_cnt < 32) begin
        cmd_sr = {cmd_sr[30:0], flash_mosi};
        if (rise_cnt == 31) begin  // command and address complete
          assert (cmd_sr[31:24] == FLASH_READ_CMD)
            else report_error($sformatf("flash command %02h", cmd_sr[31:24]));
          assert (cmd_sr[23:0] == FLASH_TRANSFER_FROM_ADDRESS)
            else report_error($sformatf("flash address %06h", cmd_sr[23:0]));
          rd_addr = 32'(cmd_sr[23:0]);
        end
      end
      rise_cnt++;
    end else if (flash_clk === 1'b0 && prev_sck && rise_cnt >= 32) begin
      // next data bit, msb first
      out_bit = flash_mem[(rd_addr + data_bit / 8) % FLASH_BYTES][7 - data_bit % 8];
      data_bit++;
    end
    prev_sck  = flash_clk === 1'b1;
    prev_cs_n = flash_cs_n;
  end

  always @(posedge clk) flash_miso <= out_bit;

  // a failed bound property ends the run here
  always @(negedge clk) begin
    if (u_dut.u_props.error_count != 0) begin
      $display("a bound protocol assertion failed");
      $display("tests failed");
      $fatal(1, "assertion failure");
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] seed;
    seed         = 32'h7dff_15d0;
    arst_n       = 1'b1;
    expected_sum = '0;
    for (int a = 0; a < FLASH_BYTES; a++) begin
      seed         = lcg_next(seed);
      flash_mem[a] = seed[31:24];
    end
    for (int i = 0; i < FLASH_TRANSFER_BYTE_COUNT; i++) begin
      expected_sum += flash_mem[FLASH_TRANSFER_FROM_ADDRESS + i];  // mod 256
    end

    @(posedge clk);
    arst_n <= 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    fork
      begin
        wait_boot_done();
        assert (led[4:1] == expected_sum[3:0])
          else report_error($sformatf("led[4:1] %h, expected %h", led[4:1], expected_sum[3:0]));
        assert (transfer_done)
          else report_error("flash transfer never completed");
      end
      begin
        receive_frame(rx_byte);
        assert (rx_byte == expected_sum)
          else report_error($sformatf("uart byte %02h, expected %02h", rx_byte, expected_sum));
      end
    join

    check_idle();

    if (u_dut.u_props.error_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "protocol assertion failed");
    end
  end

endmodule

// ==== bench/top_properties.sv ====
// top_properties
// protocol checks bound into top: reset levels, spi clock idle,
// uart framing, loader to ramio strobes and the sticky done led
`timescale 1ns/100ps

module top_properties
  import soc_pkg::*;
(
  input wire        clk,
  input wire        arst_n,
  input wire  [5:0] led,
  input wire        uart_tx,
  input wire        flash_cs_n,
  input wire        flash_clk,
  input ramio_req_t ramio_req,
  input wire        ramio_busy
);

  int error_count = 0;  // failed assertions so far
  int frame_pos;        // cycles since start bit seen, 0 while line idle

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_pos <= 0;
    end else if (frame_pos != 0) begin
      frame_pos <= (frame_pos == 10 * UART_CLKS_PER_BIT - 1) ? 0 : frame_pos + 1;
    end else if (!uart_tx) begin
      frame_pos <= 1;  // start bit
    end
  end

  // --------------------------------------------------
  // reset and pins
  // --------------------------------------------------
  a_reset_levels: assert property (@(posedge clk)
    !arst_n |-> flash_cs_n && uart_tx && led == 6'b10_0000)
    else begin
      $error("outputs not at reset levels while arst_n low");
      error_count++;
    end

  a_sck_idle: assert property (@(posedge clk) disable iff (!arst_n)
    flash_cs_n |-> !flash_clk)
    else begin
      $error("flash_clk high while flash_cs_n high");
      error_count++;
    end

  // middle of the stop bit
  a_stop_bit: assert property (@(posedge clk) disable iff (!arst_n)
    frame_pos == 9 * UART_CLKS_PER_BIT + UART_CLKS_PER_BIT / 2 - 1 |-> uart_tx)
    else begin
      $error("uart stop bit low");
      error_count++;
    end

  a_done_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    led[0] |=> led[0])
    else begin
      $error("led[0] fell after boot done");
      error_count++;
    end

  // --------------------------------------------------
  // loader / ramio strobes
  // --------------------------------------------------
  a_enable_idle: assert property (@(posedge clk) disable iff (!arst_n)
    ramio_req.enable |-> !ramio_busy ##1 ramio_busy)
    else begin
      $error("ramio enable not accepted from idle");
      error_count++;
    end

endmodule

bind top top_properties u_props (.*);

// ==== verilog/top.sv ====
// top
// reduced boot subsystem: flash_loader drives ramio, ramio drives
// burst_ram and the LED / UART registers
`timescale 1ns/100ps
`default_nettype none

module top
  import soc_pkg::*;
(
  input  wire        clk,
  input  wire        arst_n,
  output logic [5:0] led,
  output logic       uart_tx,
  output logic       flash_cs_n,
  output logic       flash_clk,
  input  wire        flash_miso,
  output logic       flash_mosi
);

  // --------------------------------------------------
  // loader <-> ramio
  // --------------------------------------------------
  ramio_req_t ramio_req;
  word_t      ramio_data_out;
  logic       ramio_data_out_ready;
  logic       ramio_busy;

  // ramio <-> burst ram
  br_req_t br_req;
  line_t   br_rd_data;
  logic    br_rd_data_valid;

  flash_loader u_flash_loader (
    .clk                 (clk),
    .arst_n              (arst_n),
    .ramio_req           (ramio_req),
    .ramio_data_out      (ramio_data_out),
    .ramio_data_out_ready(ramio_data_out_ready),
    .ramio_busy          (ramio_busy),
    .led                 (led[0]),  // boot done
    .flash_clk           (flash_clk),
    .flash_miso          (flash_miso),
    .flash_mosi          (flash_mosi),
    .flash_cs_n          (flash_cs_n)
  );

  ramio u_ramio (
    .clk             (clk),
    .arst_n          (arst_n),
    .req             (ramio_req),
    .data_out        (ramio_data_out),
    .data_out_ready  (ramio_data_out_ready),
    .busy            (ramio_busy),
    .led             (led[4:1]),  // checksum low nibble
    .uart_tx         (uart_tx),
    .br_req          (br_req),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  burst_ram u_burst_ram (
    .clk          (clk),
    .arst_n       (arst_n),
    .req          (br_req),
    .rd_data      (br_rd_data),
    .rd_data_valid(br_rd_data_valid)
  );

  assign led[5] = ~ramio_busy;  // lit while ramio idle

endmodule

`default_nettype wire

// ==== verilog/flash_loader.sv ====
// flash_loader
// boot sequencer: startup wait, spi flash read into ram through ramio,
// byte read back into a checksum, report to LED and UART, then done
`timescale 1ns/100ps
`default_nettype none

module flash_loader
  import soc_pkg::*;
(
  input  wire        clk,
  input  wire        arst_n,
  output ramio_req_t ramio_req,
  input  word_t      ramio_data_out,
  input  wire        ramio_data_out_ready,
  input  wire        ramio_busy,
  output logic       led,
  output logic       flash_clk,
  input  wire        flash_miso,
  output logic       flash_mosi,
  output logic       flash_cs_n
);

  loader_state_t state;
  logic [$clog2(STARTUP_WAIT_CYCLES)-1:0] wait_cnt;
  logic [4:0]  bit_cnt;   // 32 cmd+addr bits, low 3 bits per data byte
  logic [$clog2(FLASH_TRANSFER_BYTE_COUNT)-1:0] byte_idx;
  logic [31:0] sr;        // command and address out
  byte_t       rx_sr;     // data byte in, msb first
  byte_t       sum;

  // ramio free and no strobe from last cycle
  wire can_issue = !ramio_busy && !ramio_req.enable;
  wire last_byte = byte_idx == FLASH_TRANSFER_BYTE_COUNT - 1;

  assign flash_mosi = sr[31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= WAIT;
      wait_cnt   <= '0;
      bit_cnt    <= '0;
      byte_idx   <= '0;
      sr         <= '0;
      rx_sr      <= '0;
      sum        <= '0;
      ramio_req  <= '0;
      led        <= 1'b0;
      flash_clk  <= 1'b0;
      flash_cs_n <= 1'b1;
    end else begin
      ramio_req.enable <= 1'b0;  // single cycle
      unique case (state)
        WAIT: if (wait_cnt == STARTUP_WAIT_CYCLES - 1) begin
          flash_cs_n <= 1'b0;
          sr         <= {FLASH_READ_CMD, FLASH_TRANSFER_FROM_ADDRESS};
          state      <= FLASH_CMD;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
        // spi mode 0, sck = clk/2; shift on falling edge
        FLASH_CMD: begin
          flash_clk <= ~flash_clk;
          if (flash_clk) begin
            sr      <= {sr[30:0], 1'b0};
            bit_cnt <= bit_cnt + 5'd1;  // wraps to 0 after bit 31
            if (bit_cnt == 5'd31) state <= FLASH_BYTE;
          end
        end
        FLASH_BYTE: begin
          flash_clk <= ~flash_clk;
          if (flash_clk) begin  // sample at the end of the high phase
            rx_sr   <= {rx_sr[6:0], flash_miso};
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt[2:0] == 3'd7) state <= RAM_WRITE;
          end
        end
        // sck parked low, cs_n held until last byte
        RAM_WRITE: if (can_issue) begin
          ramio_req <= '{enable: 1'b1, read_type: RD_NONE, write_type: WR_BYTE,
                         address: word_t'(byte_idx), data_in: word_t'(rx_sr)};
          if (last_byte) begin
            flash_cs_n <= 1'b1;
            byte_idx   <= '0;
            state      <= RAM_READ;
          end else begin
            byte_idx <= byte_idx + 1'b1;
            state    <= FLASH_BYTE;
          end
        end
        RAM_READ: if (can_issue) begin
          ramio_req <= '{enable: 1'b1, read_type: RD_BYTE_U, write_type: WR_NONE,
                         address: word_t'(byte_idx), data_in: '0};
          state     <= SUM;
        end
        SUM: if (ramio_data_out_ready) begin
          sum <= sum + ramio_data_out[7:0];  // mod 256
          if (last_byte) begin
            state <= REPORT_LED;
          end else begin
            byte_idx <= byte_idx + 1'b1;
            state    <= RAM_READ;
          end
        end
        REPORT_LED: if (can_issue) begin
          ramio_req <= '{enable: 1'b1, read_type: RD_NONE, write_type: WR_WORD,
                         address: LED_ADDR, data_in: word_t'(sum)};
          state     <= REPORT_UART;
        end
        REPORT_UART: if (can_issue) begin
          ramio_req <= '{enable: 1'b1, read_type: RD_NONE, write_type: WR_BYTE,
                         address: UART_ADDR, data_in: word_t'(sum)};
          state     <= DONE;
        end
        DONE: if (can_issue) led <= 1'b1;  // sticky once uart accepted
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ramio.sv ====
// ramio
// memory and i/o port: ram accesses go out as burst ram line commands,
// LED_ADDR and UART_ADDR hit local registers
`timescale 1ns/100ps
`default_nettype none

module ramio
  import soc_pkg::*;
(
  input  wire        clk,
  input  wire        arst_n,
  input  ramio_req_t req,
  output word_t      data_out,
  output logic       data_out_ready,
  output logic       busy,
  output logic [3:0] led,
  output logic       uart_tx,
  output br_req_t    br_req,
  input  line_t      br_rd_data,
  input  wire        br_rd_data_valid
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_ACK, ST_RD_WAIT, ST_UART_WAIT, ST_UART_START
  } ramio_state_t;

  ramio_state_t state;
  ramio_req_t   req_r;  // request held for read extraction
  logic         br_cmd, br_cmd_en;
  line_addr_t   br_addr;
  line_t        br_wr_data;
  logic [7:0]   br_mask;
  byte_t        utx_data;
  logic         utx_start, utx_busy;
  word_t        rd_half;
  byte_t        rd_byte;

  wire is_ram   = ~req.address[31];  // top bit clear -> ram
  wire is_write = req.write_type != WR_NONE;

  // lane select on the returned line
  assign rd_half = req_r.address[2] ? br_rd_data[63:32] : br_rd_data[31:0];
  assign rd_byte = rd_half[req_r.address[1:0]*8+:8];

  assign busy   = state != ST_IDLE;
  assign br_req = '{cmd: br_cmd, cmd_en: br_cmd_en, addr: br_addr,
                    wr_data: br_wr_data, data_mask: br_mask};

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state          <= ST_IDLE;
      br_cmd_en      <= 1'b0;
      data_out_ready <= 1'b0;
      utx_start      <= 1'b0;
      led            <= '0;
    end else begin
      br_cmd_en      <= 1'b0;  // strobes default low
      data_out_ready <= 1'b0;
      utx_start      <= 1'b0;
      unique case (state)
        ST_IDLE: if (req.enable) begin
          if (is_ram) begin
            br_cmd_en <= 1'b1;
            state     <= is_write ? ST_ACK : ST_RD_WAIT;
          end else if (is_write && req.address == UART_ADDR) begin
            state <= ST_UART_WAIT;
          end else begin
            if (is_write && req.address == LED_ADDR) led <= req.data_in[3:0];
            state <= ST_ACK;
          end
        end
        ST_ACK: begin
          state          <= ST_IDLE;
          data_out_ready <= req_r.read_type != RD_NONE;  // register reads
        end
        ST_RD_WAIT: if (br_rd_data_valid) begin
          state          <= ST_IDLE;
          data_out_ready <= 1'b1;
        end
        ST_UART_WAIT: if (!utx_busy) begin  // previous frame still going
          utx_start <= 1'b1;
          state     <= ST_UART_START;
        end
        ST_UART_START: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // payload, no reset
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req.enable) begin
      req_r    <= req;
      br_cmd   <= is_write;
      br_addr  <= req.address[RAM_ADDRESS_BITWIDTH-1:3];
      utx_data <= req.data_in[7:0];
      if (req.write_type == WR_BYTE) begin
        br_wr_data <= {8{req.data_in[7:0]}};
        br_mask    <= ~(8'b1 << req.address[2:0]);  // one lane
      end else begin
        br_wr_data <= {2{req.data_in}};
        br_mask    <= req.address[2] ? 8'h0F : 8'hF0;  // upper or lower half
      end
    end
    if (state == ST_RD_WAIT && br_rd_data_valid) begin
      data_out <= (req_r.read_type == RD_BYTE_U) ? {24'b0, rd_byte} : rd_half;
    end else if (state == ST_ACK) begin
      data_out <= {28'b0, led};  // only LED reads back
    end
  end

  uart_tx u_uart_tx (
    .clk   (clk),
    .arst_n(arst_n),
    .data  (utx_data),
    .start (utx_start),
    .busy  (utx_busy),
    .tx    (uart_tx)
  );

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
// uart_tx
// 8N1 transmitter, lsb first, UART_CLKS_PER_BIT clocks per bit
`timescale 1ns/100ps
`default_nettype none

module uart_tx
  import soc_pkg::*;
(
  input  wire   clk,
  input  wire   arst_n,
  input  byte_t data,
  input  wire   start,  // ignored while busy
  output logic  busy,
  output logic  tx
);

  logic [$clog2(UART_CLKS_PER_BIT)-1:0] clk_cnt;  // position inside bit time
  logic [3:0] bit_idx;  // 0 start, 1..8 data, 9 stop
  logic [8:0] shift;    // {stop, data} still to send

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      tx      <= 1'b1;  // line idles high
      clk_cnt <= '0;
      bit_idx <= '0;
      shift   <= '1;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        tx      <= 1'b0;  // start bit
        shift   <= {1'b1, data};
        clk_cnt <= '0;
        bit_idx <= '0;
      end
    end else if (clk_cnt == UART_CLKS_PER_BIT - 1) begin
      clk_cnt <= '0;
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;  // stop bit done, tx already high
      end else begin
        tx      <= shift[0];
        shift   <= {1'b1, shift[8:1]};
        bit_idx <= bit_idx + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/burst_ram.sv ====
// burst_ram
// behavioral 64 bit line memory behind a psram style command port,
// byte masked writes and a fixed read latency
`timescale 1ns/100ps
`default_nettype none

module burst_ram
  import soc_pkg::*;
(
  input  wire     clk,
  input  wire     arst_n,
  input  br_req_t req,
  output line_t   rd_data,
  output logic    rd_data_valid
);

  line_t mem [2**(RAM_ADDRESS_BITWIDTH-3)];  // no reset, contents undefined

  logic [BR_READ_LATENCY-1:0] vld_pipe;  // one flag per latency stage
  line_addr_t addr_pipe [BR_READ_LATENCY];

  // --------------------------------------------------
  // write port
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (req.cmd_en && req.cmd) begin
      for (int b = 0; b < 8; b++) begin
        if (!req.data_mask[b]) begin  // mask bit clear -> write lane
          mem[req.addr][b*8+:8] <= req.wr_data[b*8+:8];
        end
      end
    end
  end

  // --------------------------------------------------
  // read pipeline
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[BR_READ_LATENCY-2:0], req.cmd_en & ~req.cmd};
    end
  end

  // address rides along, payload only
  always_ff @(posedge clk) begin
    addr_pipe[0] <= req.addr;
    for (int s = 1; s < BR_READ_LATENCY; s++) begin
      addr_pipe[s] <= addr_pipe[s-1];
    end
  end

  assign rd_data_valid = vld_pipe[BR_READ_LATENCY-1];
  assign rd_data       = mem[addr_pipe[BR_READ_LATENCY-1]];  // single read in flight

endmodule

`default_nettype wire

// ==== verilog/soc_pkg.sv ====
// soc_pkg
// shared sizes, address map, access codes and bus structs
// for the reduced boot subsystem

package soc_pkg;

  // --------------------------------------------------
  // sizes and timing
  // --------------------------------------------------
  localparam int RAM_ADDRESS_BITWIDTH = 12;  // 4 KiB, byte addressed
  localparam int BR_READ_LATENCY = 4;  // cmd_en to rd_data_valid
  localparam int STARTUP_WAIT_CYCLES = 8;
  localparam logic [23:0] FLASH_TRANSFER_FROM_ADDRESS = 24'h000100;
  localparam int FLASH_TRANSFER_BYTE_COUNT = 16;
  localparam int UART_CLKS_PER_BIT = 8;  // short, simulation only
  localparam logic [7:0] FLASH_READ_CMD = 8'h03;

  // memory mapped registers, top bit set
  localparam logic [31:0] LED_ADDR = 32'hFFFF_FFFC;
  localparam logic [31:0] UART_ADDR = 32'hFFFF_FFF8;

  // access codes
  localparam logic [2:0] RD_NONE = 3'b000;
  localparam logic [2:0] RD_BYTE_U = 3'b101;  // zero extended
  localparam logic [2:0] RD_WORD = 3'b011;
  localparam logic [1:0] WR_NONE = 2'b00;
  localparam logic [1:0] WR_BYTE = 2'b01;
  localparam logic [1:0] WR_WORD = 2'b11;

  // --------------------------------------------------
  // types
  // --------------------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [63:0] line_t;  // one burst ram line
  typedef logic [RAM_ADDRESS_BITWIDTH-4:0] line_addr_t;
  typedef logic [7:0] byte_t;

  typedef struct packed {
    logic       enable;      // one cycle strobe
    logic [2:0] read_type;
    logic [1:0] write_type;
    word_t      address;
    word_t      data_in;
  } ramio_req_t;

  typedef struct packed {
    logic       cmd;        // 0 read, 1 write
    logic       cmd_en;     // one cycle pulse
    line_addr_t addr;
    line_t      wr_data;
    logic [7:0] data_mask;  // 1 keeps the byte
  } br_req_t;

  typedef enum logic [3:0] {
    WAIT,
    FLASH_CMD,
    FLASH_BYTE,
    RAM_WRITE,
    RAM_READ,
    SUM,
    REPORT_LED,
    REPORT_UART,
    DONE
  } loader_state_t;

endpackage
